// ==== verilog/bridge_pkg.sv ====
package bridge_pkg;

    typedef logic [31:0] word_t;       // one udp payload word
    typedef logic [1:0]  axi_id_t;
    typedef logic [1:0]  axi_resp_t;
    typedef logic [1:0]  axi_burst_t;
    typedef logic [15:0] byte_num_t;   // udp reply length in bytes

    // one address header after parsing, 44 bits
    typedef struct packed {
        axi_id_t    id;
        axi_burst_t burst;
        logic [7:0] len;               // beats minus one
        word_t      addr;
    } addr_cmd_t;

    localparam logic [7:0] CMD_TAG    = 8'h00;   // marks an address packet
    localparam logic [7:0] WRBACK_TAG = 8'hF0;   // top byte of each reply word

    // channel 0 is write address, channel 1 is read address
    localparam int N_CHANNELS = 2;

endpackage

// ==== verilog/sync_fifo.sv ====
module sync_fifo #(
    parameter type payload_t = logic [31:0],
    parameter int  DEPTH     = 16
) (
    input  logic                   gmii_rx_clk,
    input  logic                   rstn,
    input  logic                   wr_en,
    input  payload_t               wr_data,
    input  logic                   rd_en,
    output payload_t               rd_data,     // head of queue, show-ahead
    output logic                   empty,
    output logic                   full,
    output logic [$clog2(DEPTH):0] level        // stored entries
);

    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;

    payload_t         mem [DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic             do_wr;
    logic             do_rd;

    assign do_wr   = wr_en && !full;     // overflow ignored
    assign do_rd   = rd_en && !empty;    // underflow ignored
    assign empty   = (level == 0);
    assign full    = (level == DEPTH);
    assign rd_data = mem[rd_ptr];

    always_ff @(posedge gmii_rx_clk) begin
        if (do_wr) begin
            mem[wr_ptr] <= wr_data;
        end
    end

    always_ff @(posedge gmii_rx_clk or negedge rstn) begin
        if (!rstn) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            level  <= '0;
        end else begin
            if (do_wr) begin
                wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (do_rd) begin
                rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            case ({do_wr, do_rd})
                2'b10:   level <= level + 1'b1;
                2'b01:   level <= level - 1'b1;
                default: level <= level;      // both or neither
            endcase
        end
    end

endmodule

// ==== verilog/cmd_parser.sv ====
module cmd_parser (
    input  logic                                gmii_rx_clk,
    input  logic                                rstn,
    input  logic                                udp_rx_en,
    input  logic                                udp_rx_done,   // with last word
    input  bridge_pkg::word_t                   udp_rx_data,
    input  logic [bridge_pkg::N_CHANNELS-1:0]   full,
    output logic [bridge_pkg::N_CHANNELS-1:0]   push,
    output bridge_pkg::addr_cmd_t               cmd
);

    typedef enum logic [1:0] {
        S_FIRST,      // waiting for header word one
        S_SECOND,     // waiting for the address word
        S_DISCARD     // rest of a foreign packet
    } state_t;

    state_t                              state;
    logic                                pkt_first;   // next word opens a packet
    bridge_pkg::word_t                   hdr;
    logic [bridge_pkg::N_CHANNELS-1:0]   route;

    // write flag set goes to channel 0, clear to channel 1
    always_comb begin
        route = '0;
        if (hdr[16]) begin
            route[0] = 1'b1;
        end else begin
            route[1] = 1'b1;
        end
    end

    always_ff @(posedge gmii_rx_clk or negedge rstn) begin
        if (!rstn) begin
            state     <= S_FIRST;
            pkt_first <= 1'b1;
            push      <= '0;
        end else begin
            push <= '0;                              // single cycle strobe
            if (udp_rx_en) begin
                pkt_first <= udp_rx_done;
                case (state)
                    S_FIRST: begin
                        if (udp_rx_done) begin
                            state <= S_FIRST;        // odd trailing word
                        end else if (pkt_first &&
                                     udp_rx_data[31:24] != bridge_pkg::CMD_TAG) begin
                            state <= S_DISCARD;
                        end else begin
                            state <= S_SECOND;
                        end
                    end
                    S_SECOND: begin
                        push  <= route & ~full;      // dropped when issuer is full
                        state <= S_FIRST;
                    end
                    S_DISCARD: begin
                        if (udp_rx_done) begin
                            state <= S_FIRST;
                        end
                    end
                    default: state <= S_FIRST;
                endcase
            end
        end
    end

    // header word one is held until its address arrives
    always_ff @(posedge gmii_rx_clk) begin
        if (udp_rx_en && state == S_FIRST) begin
            hdr <= udp_rx_data;
        end
    end

    always_ff @(posedge gmii_rx_clk) begin
        if (udp_rx_en && state == S_SECOND) begin
            cmd.burst <= hdr[23:22];
            cmd.id    <= hdr[21:20];
            cmd.len   <= hdr[15:8];
            cmd.addr  <= udp_rx_data;
        end
    end

endmodule

// ==== verilog/addr_issuer.sv ====
module addr_issuer #(
    parameter int DEPTH = 16
) (
    input  logic                  gmii_rx_clk,
    input  logic                  rstn,
    input  logic                  push,
    input  bridge_pkg::addr_cmd_t cmd,
    output logic                  full,
    output logic                  valid,
    input  logic                  ready,
    output bridge_pkg::addr_cmd_t out_cmd
);

    bridge_pkg::addr_cmd_t head;
    logic                  empty;
    logic                  pop;

    // next command leaves the queue only while the channel is idle
    assign pop = !valid && !empty;

    sync_fifo #(
        .payload_t (bridge_pkg::addr_cmd_t),
        .DEPTH     (DEPTH)
    ) u_cmd_fifo (
        .gmii_rx_clk (gmii_rx_clk),
        .rstn        (rstn),
        .wr_en       (push),
        .wr_data     (cmd),
        .rd_en       (pop),
        .rd_data     (head),
        .empty       (empty),
        .full        (full),
        .level       ()
    );

    always_ff @(posedge gmii_rx_clk or negedge rstn) begin
        if (!rstn) begin
            valid <= 1'b0;
        end else if (pop) begin
            valid <= 1'b1;          // one cycle after the pop
        end else if (ready) begin
            valid <= 1'b0;          // handshake done
        end
    end

    // fields stay put until the next pop
    always_ff @(posedge gmii_rx_clk) begin
        if (pop) begin
            out_cmd <= head;
        end
    end

endmodule

// ==== verilog/wrback_reporter.sv ====
module wrback_reporter #(
    parameter int DEPTH = 16
) (
    input  logic                  gmii_rx_clk,
    input  logic                  rstn,
    input  logic                  bvalid,
    output logic                  bready,
    input  bridge_pkg::axi_id_t   bid,
    input  bridge_pkg::axi_resp_t bresp,
    input  logic                  udp_tx_req,     // one word per cycle
    input  logic                  udp_tx_done,
    output logic                  udp_tx_start,
    output bridge_pkg::word_t     udp_tx_data,
    output bridge_pkg::byte_num_t udp_tx_byte_num
);

    typedef enum logic {
        TX_IDLE,
        TX_SEND
    } tx_state_t;

    tx_state_t                tx_state;
    logic                     ready_en;     // low until first edge after reset
    logic                     full;
    logic                     empty;
    logic [$clog2(DEPTH):0]   level;
    logic                     resp_push;
    logic                     resp_pop;
    bridge_pkg::word_t        resp_word;

    assign bready    = ready_en && !full;
    assign resp_push = bvalid && bready;
    assign resp_pop  = (tx_state == TX_SEND) && udp_tx_req;

    assign resp_word = {bridge_pkg::WRBACK_TAG, 6'b0, bid, 6'b0, bresp, 8'h00};

    sync_fifo #(
        .payload_t (bridge_pkg::word_t),
        .DEPTH     (DEPTH)
    ) u_resp_fifo (
        .gmii_rx_clk (gmii_rx_clk),
        .rstn        (rstn),
        .wr_en       (resp_push),
        .wr_data     (resp_word),
        .rd_en       (resp_pop),
        .rd_data     (udp_tx_data),   // head shown during each req
        .empty       (empty),
        .full        (full),
        .level       (level)
    );

    always_ff @(posedge gmii_rx_clk or negedge rstn) begin
        if (!rstn) begin
            ready_en <= 1'b0;
        end else begin
            ready_en <= 1'b1;
        end
    end

    always_ff @(posedge gmii_rx_clk or negedge rstn) begin
        if (!rstn) begin
            tx_state        <= TX_IDLE;
            udp_tx_start    <= 1'b0;
            udp_tx_byte_num <= '0;
        end else begin
            udp_tx_start <= 1'b0;
            case (tx_state)
                TX_IDLE: begin
                    if (!empty) begin
                        udp_tx_start    <= 1'b1;
                        // later arrivals wait for the next reply
                        udp_tx_byte_num <= bridge_pkg::byte_num_t'({level, 2'b00});
                        tx_state        <= TX_SEND;
                    end
                end
                TX_SEND: begin
                    if (udp_tx_done) begin
                        tx_state <= TX_IDLE;
                    end
                end
                default: tx_state <= TX_IDLE;
            endcase
        end
    end

endmodule

// ==== verilog/udp_axi_bridge.sv ====
module udp_axi_bridge #(
    parameter int ADDR_FIFO_DEPTH   = 16,
    parameter int WRBACK_FIFO_DEPTH = 16
) (
    input  logic                   gmii_rx_clk,
    input  logic                   rstn,

    input  logic                   udp_rx_en,
    input  logic                   udp_rx_done,
    input  bridge_pkg::word_t      udp_rx_data,

    input  logic                   udp_tx_req,
    input  logic                   udp_tx_done,
    output logic                   udp_tx_start,
    output bridge_pkg::word_t      udp_tx_data,
    output bridge_pkg::byte_num_t  udp_tx_byte_num,

    output bridge_pkg::axi_id_t    master_wr_addr_id,
    output bridge_pkg::word_t      master_wr_addr,
    output logic [7:0]             master_wr_addr_len,
    output bridge_pkg::axi_burst_t master_wr_addr_burst,
    output logic                   master_wr_addr_valid,
    input  logic                   master_wr_addr_ready,

    output bridge_pkg::axi_id_t    master_rd_addr_id,
    output bridge_pkg::word_t      master_rd_addr,
    output logic [7:0]             master_rd_addr_len,
    output bridge_pkg::axi_burst_t master_rd_addr_burst,
    output logic                   master_rd_addr_valid,
    input  logic                   master_rd_addr_ready,

    input  bridge_pkg::axi_id_t    master_wr_back_id,
    input  bridge_pkg::axi_resp_t  master_wr_back_resp,
    input  logic                   master_wr_back_valid,
    output logic                   master_wr_back_ready
);

    localparam int N = bridge_pkg::N_CHANNELS;

    logic [N-1:0]          cmd_push;
    logic [N-1:0]          cmd_full;
    logic [N-1:0]          ch_valid;
    logic [N-1:0]          ch_ready;
    bridge_pkg::addr_cmd_t parsed_cmd;
    bridge_pkg::addr_cmd_t ch_cmd [N];

    cmd_parser u_parser (
        .gmii_rx_clk (gmii_rx_clk),
        .rstn        (rstn),
        .udp_rx_en   (udp_rx_en),
        .udp_rx_done (udp_rx_done),
        .udp_rx_data (udp_rx_data),
        .full        (cmd_full),
        .push        (cmd_push),
        .cmd         (parsed_cmd)
    );

    // index 0 write address, index 1 read address
    for (genvar i = 0; i < N; i++) begin : g_issuer
        addr_issuer #(
            .DEPTH (ADDR_FIFO_DEPTH)
        ) u_issuer (
            .gmii_rx_clk (gmii_rx_clk),
            .rstn        (rstn),
            .push        (cmd_push[i]),
            .cmd         (parsed_cmd),
            .full        (cmd_full[i]),
            .valid       (ch_valid[i]),
            .ready       (ch_ready[i]),
            .out_cmd     (ch_cmd[i])
        );
    end

    assign ch_ready = {master_rd_addr_ready, master_wr_addr_ready};

    assign master_wr_addr_valid = ch_valid[0];
    assign master_wr_addr_id    = ch_cmd[0].id;
    assign master_wr_addr       = ch_cmd[0].addr;
    assign master_wr_addr_len   = ch_cmd[0].len;
    assign master_wr_addr_burst = ch_cmd[0].burst;

    assign master_rd_addr_valid = ch_valid[1];
    assign master_rd_addr_id    = ch_cmd[1].id;
    assign master_rd_addr       = ch_cmd[1].addr;
    assign master_rd_addr_len   = ch_cmd[1].len;
    assign master_rd_addr_burst = ch_cmd[1].burst;

    wrback_reporter #(
        .DEPTH (WRBACK_FIFO_DEPTH)
    ) u_reporter (
        .gmii_rx_clk     (gmii_rx_clk),
        .rstn            (rstn),
        .bvalid          (master_wr_back_valid),
        .bready          (master_wr_back_ready),
        .bid             (master_wr_back_id),
        .bresp           (master_wr_back_resp),
        .udp_tx_req      (udp_tx_req),
        .udp_tx_done     (udp_tx_done),
        .udp_tx_start    (udp_tx_start),
        .udp_tx_data     (udp_tx_data),
        .udp_tx_byte_num (udp_tx_byte_num)
    );

endmodule

// ==== verification/udp_axi_bridge_assert.sv ====
module udp_axi_bridge_assert (
    input logic                   gmii_rx_clk,
    input logic                   rstn,
    input bridge_pkg::axi_id_t    master_wr_addr_id,
    input bridge_pkg::word_t      master_wr_addr,
    input logic [7:0]             master_wr_addr_len,
    input bridge_pkg::axi_burst_t master_wr_addr_burst,
    input logic                   master_wr_addr_valid,
    input logic                   master_wr_addr_ready,
    input bridge_pkg::axi_id_t    master_rd_addr_id,
    input bridge_pkg::word_t      master_rd_addr,
    input logic [7:0]             master_rd_addr_len,
    input bridge_pkg::axi_burst_t master_rd_addr_burst,
    input logic                   master_rd_addr_valid,
    input logic                   master_rd_addr_ready,
    input logic                   udp_tx_start
);
    timeunit 1ns;
    timeprecision 100ps;

    int n_fail = 0;   // failed assertions so far

    // a waiting command keeps valid and every field
    wr_hold: assert property (@(posedge gmii_rx_clk) disable iff (!rstn)
        master_wr_addr_valid && !master_wr_addr_ready |=> master_wr_addr_valid &&
        $stable({master_wr_addr_id, master_wr_addr, master_wr_addr_len, master_wr_addr_burst}))
        else begin
            $error("write address changed before ready");
            n_fail++;
        end

    rd_hold: assert property (@(posedge gmii_rx_clk) disable iff (!rstn)
        master_rd_addr_valid && !master_rd_addr_ready |=> master_rd_addr_valid &&
        $stable({master_rd_addr_id, master_rd_addr, master_rd_addr_len, master_rd_addr_burst}))
        else begin
            $error("read address changed before ready");
            n_fail++;
        end

    start_pulse: assert property (@(posedge gmii_rx_clk) disable iff (!rstn)
        udp_tx_start |=> !udp_tx_start)
        else begin
            $error("udp_tx_start longer than one cycle");
            n_fail++;
        end

    quiet_in_reset: assert property (@(posedge gmii_rx_clk)
        !rstn |-> !master_wr_addr_valid && !master_rd_addr_valid)
        else begin
            $error("address valid high during reset");
            n_fail++;
        end

endmodule

bind udp_axi_bridge udp_axi_bridge_assert u_assert (.*);

// ==== verification/tb_udp_axi_bridge.sv ====
module tb_udp_axi_bridge;
    timeunit 1ns;
    timeprecision 100ps;

    typedef struct packed {
        logic        single;   // one word only
        logic        last;     // udp_rx_done on the final word
        logic [31:0] w0;
        logic [31:0] w1;
        logic [1:0]  chan;     // 0 write, 1 read, 2 nothing expected
        logic [1:0]  id;
        logic [1:0]  burst;
        logic [7:0]  len;
        logic [31:0] addr;
    } row_t;

    localparam int N_ROWS = 7;
    localparam int N_RESP = 4;
    localparam int LIMIT  = 40 * (N_ROWS + N_RESP) + 200;

    localparam row_t ROWS [N_ROWS] = '{
        '{1'b0, 1'b1, 32'h0061_0700, 32'h1000_0040, 2'd0, 2'd2, 2'd1, 8'h07, 32'h1000_0040},
        '{1'b0, 1'b1, 32'h0090_0F00, 32'h2000_0100, 2'd1, 2'd1, 2'd2, 8'h0F, 32'h2000_0100},
        '{1'b0, 1'b0, 32'h0071_0300, 32'h3000_0000, 2'd0, 2'd3, 2'd1, 8'h03, 32'h3000_0000},
        '{1'b0, 1'b0, 32'h0000_0100, 32'h3000_0010, 2'd1, 2'd0, 2'd0, 8'h01, 32'h3000_0010},
        '{1'b0, 1'b0, 32'h0091_FF00, 32'h3000_0020, 2'd0, 2'd1, 2'd2, 8'hFF, 32'h3000_0020},
        '{1'b1, 1'b1, 32'h0001_0000, 32'h0000_0000, 2'd2, 2'd0, 2'd0, 8'h00, 32'h0000_0000},
        '{1'b0, 1'b1, 32'hAB41_0200, 32'h4000_0000, 2'd2, 2'd0, 2'd0, 8'h00, 32'h0000_0000}
    };

    // write responses as {id, resp}
    localparam logic [3:0] RESPS [N_RESP] = '{4'b01_00, 4'b10_10, 4'b11_00, 4'b00_11};

    logic        gmii_rx_clk;
    logic        rstn;
    logic        udp_rx_en, udp_rx_done;
    logic        udp_tx_req, udp_tx_done, udp_tx_start;
    logic [31:0] udp_rx_data, udp_tx_data;
    logic [15:0] udp_tx_byte_num;
    logic [31:0] master_wr_addr, master_rd_addr;
    logic [1:0]  master_wr_addr_id, master_wr_addr_burst;
    logic [1:0]  master_rd_addr_id, master_rd_addr_burst;
    logic [7:0]  master_wr_addr_len, master_rd_addr_len;
    logic        master_wr_addr_valid, master_wr_addr_ready;
    logic        master_rd_addr_valid, master_rd_addr_ready;
    logic [1:0]  master_wr_back_id, master_wr_back_resp;
    logic        master_wr_back_valid, master_wr_back_ready;

    integer      seed = 32'h262dac42;
    logic [31:0] rnd;
    int          errors = 0;
    int          err_mark = 0;
    int          assert_seen = 0;
    int          tests = 0;
    int          failed = 0;
    int          cycles = 0;
    logic [43:0] exp_wr [$], exp_rd [$], got_wr [$], got_rd [$];   // {id, burst, len, addr}
    logic [43:0] held [2];
    logic [1:0]  holding = 2'b00;

    udp_axi_bridge dut0 (.*);

    initial begin
        gmii_rx_clk = 1'b0;
        forever #20 gmii_rx_clk = ~gmii_rx_clk;
    end

    always @(posedge gmii_rx_clk) begin
        cycles++;
        if (cycles >= LIMIT) begin
            $display("timeout: run did not finish within %0d cycles", LIMIT);
            $display("Finished with errors");
            $finish;
        end
    end

    always @(posedge gmii_rx_clk) begin   // random back-pressure on both channels
        rnd = $random(seed);
        master_wr_addr_ready <= rnd[3];
        master_rd_addr_ready <= rnd[9];
    end

    always @(negedge gmii_rx_clk) begin : addr_monitor
        logic [43:0] cur [2];
        logic [1:0]  vld;
        logic [1:0]  rdy;
        cur[0] = {master_wr_addr_id, master_wr_addr_burst, master_wr_addr_len, master_wr_addr};
        cur[1] = {master_rd_addr_id, master_rd_addr_burst, master_rd_addr_len, master_rd_addr};
        vld = {master_rd_addr_valid, master_wr_addr_valid};
        rdy = {master_rd_addr_ready, master_wr_addr_ready};
        for (int ch = 0; ch < 2; ch++) begin
            if (vld[ch]) begin
                if (holding[ch] && cur[ch] !== held[ch]) begin
                    errors++;
                    $display("error at %0t: %s fields expected %h got %h", $time,
                             ch ? "master_rd_addr" : "master_wr_addr", held[ch], cur[ch]);
                end
                held[ch] = cur[ch];
                holding[ch] = !rdy[ch];
                if (rdy[ch] && ch == 0) got_wr.push_back(cur[ch]);
                if (rdy[ch] && ch == 1) got_rd.push_back(cur[ch]);
            end
        end
    end

    function automatic logic [31:0] reply_word(input logic [3:0] r);
        reply_word = 32'hF000_0000 | ({30'b0, r[3:2]} << 16) | ({30'b0, r[1:0]} << 8);
    endfunction

    task automatic check_val(input string name, input logic [31:0] exp_v,
                             input logic [31:0] got_v);
        if (exp_v !== got_v) begin
            errors++;
            $display("error at %0t: %s expected %h got %h", $time, name, exp_v, got_v);
        end
    endtask

    task automatic finish_test(input string what);
        errors += dut0.u_assert.n_fail - assert_seen;
        assert_seen = dut0.u_assert.n_fail;
        tests++;
        if (errors == err_mark) $display("test %0d %s: ok", tests, what);
        else begin
            failed++;
            $display("test %0d %s: failed", tests, what);
        end
        err_mark = errors;
    endtask

    task automatic send_word(input logic [31:0] w, input logic last);
        @(posedge gmii_rx_clk);
        udp_rx_en   <= 1'b1;
        udp_rx_data <= w;
        udp_rx_done <= last;
    endtask

    task automatic compare_channel(input int ch);
        string       pfx;
        int          n_exp;
        int          n_got;
        logic [43:0] e;
        logic [43:0] g;
        pfx   = ch ? "master_rd_addr" : "master_wr_addr";
        n_exp = ch ? exp_rd.size() : exp_wr.size();
        n_got = ch ? got_rd.size() : got_wr.size();
        if (n_exp != n_got) begin
            errors++;
            $display("%s channel completed %0d handshakes where %0d were expected",
                     pfx, n_got, n_exp);
        end
        for (int k = 0; k < n_exp && k < n_got; k++) begin
            e = ch ? exp_rd.pop_front() : exp_wr.pop_front();
            g = ch ? got_rd.pop_front() : got_wr.pop_front();
            check_val({pfx, "_id"}, e[43:42], g[43:42]);
            check_val({pfx, "_burst"}, e[41:40], g[41:40]);
            check_val({pfx, "_len"}, e[39:32], g[39:32]);
            check_val(pfx, e[31:0], g[31:0]);
        end
        if (ch) begin
            exp_rd.delete();
            got_rd.delete();
        end else begin
            exp_wr.delete();
            got_wr.delete();
        end
    endtask

    task automatic drive_resp(input logic [3:0] r);
        @(posedge gmii_rx_clk);
        master_wr_back_valid <= 1'b1;
        master_wr_back_id    <= r[3:2];
        master_wr_back_resp  <= r[1:0];
        @(negedge gmii_rx_clk);
        while (!master_wr_back_ready) @(negedge gmii_rx_clk);
        @(posedge gmii_rx_clk);
        master_wr_back_valid <= 1'b0;
    endtask

    task automatic wait_reply_start(input int n_words);
        @(negedge gmii_rx_clk);
        for (int k = 0; k < 20 && !udp_tx_start; k++) @(negedge gmii_rx_clk);
        if (!udp_tx_start) begin
            errors++;
            $display("udp_tx_start never rose although responses were queued");
        end else begin
            check_val("udp_tx_byte_num", 4 * n_words, udp_tx_byte_num);
        end
    endtask

    task automatic serve_reply(input int first, input int n_words);
        for (int k = first; k < first + n_words; k++) begin
            @(posedge gmii_rx_clk);
            udp_tx_req <= 1'b1;
            @(negedge gmii_rx_clk);
            check_val("udp_tx_data", reply_word(RESPS[k]), udp_tx_data);
        end
        @(posedge gmii_rx_clk);
        udp_tx_req  <= 1'b0;
        udp_tx_done <= 1'b1;
        @(posedge gmii_rx_clk);
        udp_tx_done <= 1'b0;
    endtask

    initial begin : stimulus
        int first_row;
        rstn <= 1'b0;
        udp_rx_en <= 1'b0;
        udp_rx_done <= 1'b0;
        udp_rx_data <= '0;
        udp_tx_req <= 1'b0;
        udp_tx_done <= 1'b0;
        master_wr_addr_ready <= 1'b0;
        master_rd_addr_ready <= 1'b0;
        master_wr_back_id <= '0;
        master_wr_back_resp <= '0;
        master_wr_back_valid <= 1'b0;
        repeat (8) @(posedge gmii_rx_clk);
        rstn <= 1'b1;
        @(negedge gmii_rx_clk);
        check_val("master_wr_addr_valid", 0, master_wr_addr_valid);
        check_val("master_rd_addr_valid", 0, master_rd_addr_valid);
        check_val("udp_tx_start", 0, udp_tx_start);
        check_val("udp_tx_byte_num", 0, udp_tx_byte_num);
        check_val("master_wr_back_ready", 0, master_wr_back_ready);
        @(negedge gmii_rx_clk);
        check_val("master_wr_back_ready", 1, master_wr_back_ready);   // one cycle after release
        finish_test("reset values");

        first_row = 0;
        for (int r = 0; r < N_ROWS; r++) begin
            send_word(ROWS[r].w0, ROWS[r].single && ROWS[r].last);
            if (!ROWS[r].single) send_word(ROWS[r].w1, ROWS[r].last);
            if (ROWS[r].chan == 0) begin
                exp_wr.push_back({ROWS[r].id, ROWS[r].burst, ROWS[r].len, ROWS[r].addr});
            end
            if (ROWS[r].chan == 1) begin
                exp_rd.push_back({ROWS[r].id, ROWS[r].burst, ROWS[r].len, ROWS[r].addr});
            end
            if (ROWS[r].last) begin
                @(posedge gmii_rx_clk);
                udp_rx_en   <= 1'b0;
                udp_rx_done <= 1'b0;
                for (int k = 0; k < 40 && (got_wr.size() < exp_wr.size() ||
                                           got_rd.size() < exp_rd.size()); k++) begin
                    @(posedge gmii_rx_clk);
                end
                repeat (12) @(posedge gmii_rx_clk);   // catch extra commands
                if (holding != 2'b00) begin
                    errors++;
                    $display("an address valid is still waiting after the packet was handled");
                end
                compare_channel(0);
                compare_channel(1);
                finish_test($sformatf("packet of table rows %0d to %0d", first_row, r));
                first_row = r + 1;
            end
        end

        drive_resp(RESPS[0]);
        wait_reply_start(1);
        for (int k = 1; k < N_RESP; k++) drive_resp(RESPS[k]);   // reply still open
        serve_reply(0, 1);
        finish_test("reply with one write response");
        wait_reply_start(3);
        serve_reply(1, 3);
        finish_test("reply with three write responses");

        $display("tests %0d, failed %0d, errors %0d", tests, failed, errors);
        if (errors == 0) $display("Finished with no errors");
        else $display("Finished with errors");
        $finish;
    end

endmodule

// ==== list.f ====
verilog/bridge_pkg.sv
verilog/sync_fifo.sv
verilog/cmd_parser.sv
verilog/addr_issuer.sv
verilog/wrback_reporter.sv
verilog/udp_axi_bridge.sv
verification/udp_axi_bridge_assert.sv
verification/tb_udp_axi_bridge.sv
